// ==== design/fb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_ram (
    input  wire logic              i_clk,
    fb_write_if.sink               i_wr,
    input  wire logic              i_rd_en,
    input  wire vga_pkg::fb_addr_t i_rd_addr,
    output vga_pkg::fb_word_t      o_rd_data
);
    import vga_pkg::*;

    // 160x120 pixels, 4 bits each, eight per word
    (* ram_style = "block" *)
    fb_word_t mem [FB_WORDS];

    // ====================
    // write port
    // ====================
    // byte lanes written independently
    always_ff @(posedge i_clk) begin
        if (i_wr.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (i_wr.lanes[i]) begin
                    mem[i_wr.addr][8*i +: 8] <= i_wr.data[8*i +: 8];
                end
            end
        end
    end

    // ====================
    // read port
    // ====================
    // one word per cycle, data valid the cycle after the address
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/fb_store_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_store_port (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_store_en,
    input  wire vga_pkg::store_addr_t i_store_addr,
    input  wire vga_pkg::store_size_t i_store_size,
    input  wire vga_pkg::fb_word_t    i_store_data,
    fb_write_if.source                o_wr
);
    import vga_pkg::*;

    logic [6:0] row;
    logic [6:0] col;
    logic [1:0] lane;
    logic       in_bounds;
    logic       size_ok;
    logic       accept;
    fb_addr_t   word_idx;
    fb_lanes_t  lanes;
    fb_word_t   placed;

    // row in bits 14:8, byte column in bits 6:0
    assign row  = i_store_addr[14:8];
    assign col  = i_store_addr[6:0];
    assign lane = i_store_addr[1:0];

    assign in_bounds = (row < 7'(FB_HEIGHT)) && (col < 7'(FB_ROW_BYTES));

    // word index = row * 20 + col / 4
    assign word_idx = fb_addr_t'(row) * fb_addr_t'(FB_ROW_WORDS) + fb_addr_t'(col[6:2]);

    // lane enables and data placement by size
    always_comb begin
        size_ok = 1'b1;
        lanes   = '0;
        placed  = i_store_data;
        case (i_store_size)
            SIZE_BYTE: begin
                lanes  = fb_lanes_t'(4'b0001 << lane);
                placed = {4{i_store_data[7:0]}};
            end
            SIZE_HALF: begin
                lanes  = lane[1] ? 4'b1100 : 4'b0011;
                placed = {2{i_store_data[15:0]}};
            end
            SIZE_WORD: begin
                lanes = 4'b1111;
            end
            default: begin
                size_ok = 1'b0;
            end
        endcase
    end

    assign accept = i_store_en && in_bounds && size_ok;

    // strobe is a one-cycle pulse per accepted store
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr.wr <= 1'b0;
        end else begin
            o_wr.wr <= accept;
        end
    end

    // payload only moves on an accepted store
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_wr.addr  <= word_idx;
            o_wr.lanes <= lanes;
            o_wr.data  <= placed;
        end
    end

endmodule

`default_nettype wire

// ==== design/fb_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one word write into the framebuffer, data already in its lanes
interface fb_write_if;
    import vga_pkg::*;

    logic      wr;
    fb_addr_t  addr;
    fb_lanes_t lanes;
    fb_word_t  data;

    modport source (
        output wr,
        output addr,
        output lanes,
        output data
    );

    modport sink (
        input wr,
        input addr,
        input lanes,
        input data
    );

endinterface

`default_nettype wire

// ==== design/vga_fb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_fb_top #(
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_store_en,
    input  wire vga_pkg::store_addr_t i_store_addr,
    input  wire vga_pkg::store_size_t i_store_size,
    input  wire vga_pkg::fb_word_t    i_store_data,
    output logic                      o_hsync,
    output logic                      o_vsync,
    output logic                      o_de,
    output vga_pkg::pixel_t           o_color
);
    import vga_pkg::*;

    // scanner read path
    logic     rd_en;
    fb_addr_t rd_addr;
    fb_word_t rd_data;

    // decoded word writes
    fb_write_if wr_bus ();

    fb_store_port store_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_store_en   (i_store_en),
        .i_store_addr (i_store_addr),
        .i_store_size (i_store_size),
        .i_store_data (i_store_data),
        .o_wr         (wr_bus.source)
    );

    fb_ram ram_i (
        .i_clk     (i_clk),
        .i_wr      (wr_bus.sink),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    vga_scan #(
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) scan_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .o_hsync   (o_hsync),
        .o_vsync   (o_vsync),
        .o_de      (o_de),
        .o_color   (o_color)
    );

endmodule

`default_nettype wire

// ==== design/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // ====================
    // framebuffer geometry
    // ====================
    localparam int FB_WIDTH     = 160;
    localparam int FB_HEIGHT    = 120;
    localparam int FB_WORDS     = 2400;
    localparam int FB_ROW_WORDS = 20;
    localparam int FB_ROW_BYTES = 80;

    // eight 4-bit pixels per word, pixel 0 in bits 3:0
    typedef logic [31:0] fb_word_t;
    typedef logic [11:0] fb_addr_t;
    typedef logic [3:0]  fb_lanes_t;
    typedef logic [3:0]  pixel_t;

    // ====================
    // store port
    // ====================
    typedef logic [31:0] store_addr_t;
    typedef logic [1:0]  store_size_t;

    // code 3 is not a valid size
    localparam store_size_t SIZE_BYTE = 2'd0;
    localparam store_size_t SIZE_HALF = 2'd1;
    localparam store_size_t SIZE_WORD = 2'd2;

    // ====================
    // raster
    // ====================
    typedef logic [9:0] scan_coord_t;

    // fixed, the 4x pixel scale is tied to these
    localparam int H_ACTIVE = 640;
    localparam int V_ACTIVE = 480;

    // vertical phase of the frame
    typedef enum logic [1:0] {
        SCAN_ACTIVE,
        SCAN_FRONT,
        SCAN_SYNC,
        SCAN_BACK
    } scan_state_e;

endpackage

`default_nettype wire

// ==== design/vga_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_scan #(
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    output logic                   o_rd_en,
    output vga_pkg::fb_addr_t      o_rd_addr,
    input  wire vga_pkg::fb_word_t i_rd_data,
    output logic                   o_hsync,
    output logic                   o_vsync,
    output logic                   o_de,
    output vga_pkg::pixel_t        o_color
);
    import vga_pkg::*;

    // line and frame boundaries
    localparam scan_coord_t H_LAST     = scan_coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam scan_coord_t H_SYNC_BEG = scan_coord_t'(H_ACTIVE + H_FRONT);
    localparam scan_coord_t H_SYNC_END = scan_coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam scan_coord_t V_ACT_LAST = scan_coord_t'(V_ACTIVE - 1);
    localparam scan_coord_t V_FP_LAST  = scan_coord_t'(V_ACTIVE + V_FRONT - 1);
    localparam scan_coord_t V_SY_LAST  = scan_coord_t'(V_ACTIVE + V_FRONT + V_SYNC - 1);
    localparam scan_coord_t V_LAST     = scan_coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    scan_coord_t h_cnt;
    scan_coord_t v_cnt;
    scan_state_e v_state;
    logic        line_end;
    logic        visible;
    logic        hsync_n;
    logic        vsync_n;
    logic [14:0] pix_idx;

    // pipeline stage one
    logic        vis_d1;
    logic        hs_d1;
    logic        vs_d1;
    logic [2:0]  nib_d1;

    // ====================
    // raster counters
    // ====================
    assign line_end = (h_cnt == H_LAST);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            v_state <= SCAN_ACTIVE;
        end else begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            if (line_end) begin
                v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
                // vertical phase moves with v_cnt
                case (v_state)
                    SCAN_ACTIVE: if (v_cnt == V_ACT_LAST) v_state <= SCAN_FRONT;
                    SCAN_FRONT:  if (v_cnt == V_FP_LAST)  v_state <= SCAN_SYNC;
                    SCAN_SYNC:   if (v_cnt == V_SY_LAST)  v_state <= SCAN_BACK;
                    SCAN_BACK:   if (v_cnt == V_LAST)     v_state <= SCAN_ACTIVE;
                    default:     v_state <= SCAN_ACTIVE;
                endcase
            end
        end
    end

    assign visible = (h_cnt < scan_coord_t'(H_ACTIVE)) && (v_state == SCAN_ACTIVE);
    assign hsync_n = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
    assign vsync_n = (v_state != SCAN_SYNC);

    // ====================
    // pixel fetch
    // ====================
    // each stored pixel covers 4x4 screen pixels
    assign pix_idx   = 15'(v_cnt[8:2]) * 15'(FB_WIDTH) + 15'(h_cnt[9:2]);
    assign o_rd_en   = visible;
    assign o_rd_addr = visible ? pix_idx[14:3] : '0;

    // stage one lines up with the RAM read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vis_d1 <= 1'b0;
            hs_d1  <= 1'b1;
            vs_d1  <= 1'b1;
        end else begin
            vis_d1 <= visible;
            hs_d1  <= hsync_n;
            vs_d1  <= vsync_n;
        end
    end

    always_ff @(posedge i_clk) begin
        nib_d1 <= pix_idx[2:0];
    end

    // stage two, nibble select and outputs
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_hsync <= 1'b1;
            o_vsync <= 1'b1;
            o_de    <= 1'b0;
            o_color <= '0;
        end else begin
            o_hsync <= hs_d1;
            o_vsync <= vs_d1;
            o_de    <= vis_d1;
            o_color <= vis_d1 ? i_rd_data[{nib_d1, 2'b00} +: 4] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_vga_fb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_fb;
    import vga_pkg::*;

    // short porches keep a frame near 320k cycles
    localparam int H_FRONT = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BACK  = 4;
    localparam int V_FRONT = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 2;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int CHECKED_PIXELS  = 3 * H_ACTIVE * V_ACTIVE;
    localparam int WATCHDOG_CYCLES = 4 * H_TOTAL * V_TOTAL + FB_WORDS + 1000;

    logic        clk;
    logic        reset;
    logic        store_en;
    store_addr_t store_addr;
    store_size_t store_size;
    fb_word_t    store_data;
    logic        hsync;
    logic        vsync;
    logic        de;
    pixel_t      color;

    // framebuffer model, one entry per pixel
    pixel_t      fb_model [FB_WIDTH * FB_HEIGHT];
    int          seed;
    int          cnt_h;
    int          cnt_v;
    logic        started = 1'b0;
    logic        color_check_on = 1'b0;
    int          pixels_checked = 0;
    // expected {de, hsync, vsync} and pixel index, two stages
    logic [2:0]  sync_d1;
    logic [2:0]  sync_d2;
    int          pix_d1;
    int          pix_d2;

    vga_fb_top #(
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) dut_i (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_store_en   (store_en),
        .i_store_addr (store_addr),
        .i_store_size (store_size),
        .i_store_data (store_data),
        .o_hsync      (hsync),
        .o_vsync      (vsync),
        .o_de         (de),
        .o_color      (color)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // raster model
    // ====================
    always @(posedge clk) begin
        if (reset) begin
            cnt_h   <= 0;
            cnt_v   <= 0;
            sync_d1 <= 3'b011;
            sync_d2 <= 3'b011;
            started <= 1'b1;
        end else begin
            cnt_h <= (cnt_h == H_TOTAL - 1) ? 0 : cnt_h + 1;
            if (cnt_h == H_TOTAL - 1) begin
                cnt_v <= (cnt_v == V_TOTAL - 1) ? 0 : cnt_v + 1;
            end
            // syncs are active low
            sync_d1 <= {(cnt_h < H_ACTIVE) && (cnt_v < V_ACTIVE),
                        !(cnt_h >= H_ACTIVE + H_FRONT && cnt_h < H_ACTIVE + H_FRONT + H_SYNC),
                        !(cnt_v >= V_ACTIVE + V_FRONT && cnt_v < V_ACTIVE + V_FRONT + V_SYNC)};
            pix_d1  <= (cnt_v / 4) * FB_WIDTH + cnt_h / 4;
            sync_d2 <= sync_d1;
            pix_d2  <= pix_d1;
        end
    end

    // outputs settle after the rising edge, compare on the falling one
    always @(negedge clk) begin
        if (started) begin
            assert ({de, hsync, vsync} == sync_d2) else
                fail_check($sformatf("de/hsync/vsync %b, expected %b", {de, hsync, vsync}, sync_d2));
            assert (de || color == '0) else
                fail_check($sformatf("color %h while de is low", color));
            if (color_check_on && sync_d2[2]) begin
                assert (color == fb_model[pix_d2]) else
                    fail_check($sformatf("pixel %0d shows color %h, expected %h",
                                         pix_d2, color, fb_model[pix_d2]));
                pixels_checked++;
            end
        end
    end

    task automatic fail_check(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    // ====================
    // store driver
    // ====================
    task automatic store(input int row, input int col, input store_size_t size,
                         input fb_word_t data);
        int first;
        int count;
        @(posedge clk);
        #1;
        store_en   = 1'b1;
        store_addr = store_addr_t'(row * 256 + col);
        store_size = size;
        store_data = data;
        // byte column c holds pixels 2c and 2c+1
        if (row < FB_HEIGHT && col < FB_ROW_BYTES && size != 2'd3) begin
            first = (size == SIZE_BYTE) ? col : col - col % 4;
            if (size == SIZE_HALF && col % 4 >= 2) begin
                first = first + 2;
            end
            count = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
            for (int i = 0; i < count; i++) begin
                fb_model[row * FB_WIDTH + 2 * (first + i)]     = data[8 * i +: 4];
                fb_model[row * FB_WIDTH + 2 * (first + i) + 1] = data[8 * i + 4 +: 4];
            end
        end
    endtask

    task automatic stop_stores();
        @(posedge clk);
        #1;
        store_en = 1'b0;
    endtask

    // a few cycles into vertical blanking, after the last visible pixel
    task automatic wait_vblank();
        do begin
            @(posedge clk);
            #1;
        end while (!(cnt_v == V_ACTIVE && cnt_h == 2));
    endtask

    function automatic fb_word_t fill_word(input int idx);
        logic [11:0] w;
        w = 12'(idx);
        return {w, w ^ 12'ha5c, w[7:0] ^ w[11:4]};
    endfunction

    // ====================
    // test sequence
    // ====================
    initial begin
        logic [31:0] r;
        int col;
        seed       = 32'h77d5_1211;
        reset      = 1'b1;
        store_en   = 1'b0;
        store_addr = '0;
        store_size = '0;
        store_data = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // known contents everywhere before any pixel is compared
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int w = 0; w < FB_ROW_WORDS; w++) begin
                store(y, 4 * w, SIZE_WORD, fill_word(y * FB_ROW_WORDS + w));
            end
        end
        stop_stores();
        wait_vblank();
        color_check_on = 1'b1;
        // word stores, unaligned columns write the whole word too
        repeat (64) begin
            r = $random(seed);
            store(int'(r[15:8]) % FB_HEIGHT, int'(r[7:0]) % FB_ROW_BYTES, SIZE_WORD, $random(seed));
        end
        stop_stores();
        wait_vblank();
        // byte lanes 0-3, then halfwords at offsets 0-3
        for (int k = 0; k < 24; k++) begin
            r   = $random(seed);
            col = 4 * (int'(r[7:0]) % FB_ROW_WORDS) + k % 4;
            store(int'(r[15:8]) % FB_HEIGHT, col, (k % 8 < 4) ? SIZE_BYTE : SIZE_HALF,
                  $random(seed));
        end
        stop_stores();
        wait_vblank();
        // row out of range, column out of range, bad size
        for (int k = 0; k < 8; k++) begin
            store(FB_HEIGHT + k, 4 * k, SIZE_WORD, $random(seed));
            store(k, FB_ROW_BYTES + 6 * k, SIZE_WORD, $random(seed));
            store(k, 4 * k, 2'd3, $random(seed));
        end
        stop_stores();
        wait_vblank();
        if (pixels_checked == CHECKED_PIXELS) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d pixels were compared", pixels_checked, CHECKED_PIXELS);
            $display("TESTBENCH FAILED");
            $fatal(1, "pixel compare count is wrong");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/vga_pkg.sv
design/fb_write_if.sv
design/fb_store_port.sv
design/fb_ram.sv
design/vga_scan.sv
design/vga_fb_top.sv
dv/tb_vga_fb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vga framebuffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vga_fb -Mdir obj_dir -f filelist.f

./obj_dir/Vtb_vga_fb 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
